// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_int_core
RTL_TOP   ?= rv_int_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath width
`define XLEN 32

// architectural registers, x0 included
`define NREGS 32

`endif

// ==== design/rv_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_decode_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  rv_pkg::instr_u              instr,
	input  logic [`XLEN-1:0]            pc,
	input  logic                        fwd_valid,
	input  logic [$clog2(`NREGS)-1:0]   fwd_rd,
	input  logic [`XLEN-1:0]            fwd_value,
	input  logic [`XLEN-1:0]            rdata1,
	input  logic [`XLEN-1:0]            rdata2,
	output logic [$clog2(`NREGS)-1:0]   raddr1,
	output logic [$clog2(`NREGS)-1:0]   raddr2,
	output logic                        d_valid,
	output logic [$clog2(`NREGS)-1:0]   d_rd,
	output logic [2:0]                  d_funct3,
	output logic [`XLEN-1:0]            d_op1,
	output logic [`XLEN-1:0]            d_op2,
	output logic [`XLEN-1:0]            d_imm,
	output logic [`XLEN-1:0]            d_pc,
	output rv_pkg::alu_op_e             d_alu_op,
	output rv_pkg::iclass_e             d_iclass
);
	import rv_pkg::*;

	logic [$clog2(`NREGS)-1:0] dec_rd;
	logic [2:0]                dec_funct3;
	logic [`XLEN-1:0]          dec_imm;
	logic [`XLEN-1:0]          op1;
	logic [`XLEN-1:0]          op2;
	alu_op_e                   dec_alu_op;
	iclass_e                   dec_iclass;

	rv_pre_decoder u_pre_decoder (
		.instr  (instr),
		.rd     (dec_rd),
		.rs1    (raddr1),
		.rs2    (raddr2),
		.funct3 (dec_funct3),
		.funct7 (),
		.imm    (dec_imm),
		.alu_op (dec_alu_op),
		.iclass (dec_iclass)
	);

	// the instruction in execute is one ahead of this one
	assign op1 = (fwd_valid && (fwd_rd == raddr1)) ? fwd_value : rdata1;
	assign op2 = (fwd_valid && (fwd_rd == raddr2)) ? fwd_value : rdata2;

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			d_rd     <= dec_rd;
			d_funct3 <= dec_funct3;
			d_op1    <= op1;
			d_op2    <= op2;
			d_imm    <= dec_imm;
			d_pc     <= pc;
			d_alu_op <= dec_alu_op;
			d_iclass <= dec_iclass;
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_execute (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        d_valid,
	input  logic [$clog2(`NREGS)-1:0]   d_rd,
	input  logic [2:0]                  d_funct3,
	input  logic [`XLEN-1:0]            d_op1,
	input  logic [`XLEN-1:0]            d_op2,
	input  logic [`XLEN-1:0]            d_imm,
	input  logic [`XLEN-1:0]            d_pc,
	input  rv_pkg::alu_op_e             d_alu_op,
	input  rv_pkg::iclass_e             d_iclass,
	output logic                        fwd_valid,
	output logic [$clog2(`NREGS)-1:0]   fwd_rd,
	output logic [`XLEN-1:0]            fwd_value,
	output logic                        x_valid,
	output rv_pkg::iclass_e             x_iclass,
	output logic [$clog2(`NREGS)-1:0]   x_rd,
	output logic [`XLEN-1:0]            x_alu_value,
	output logic [`XLEN-1:0]            x_link,
	output logic                        x_redirect,
	output logic [`XLEN-1:0]            x_redirect_pc
);
	import rv_pkg::*;

	logic [`XLEN-1:0]          alu_a;
	logic [`XLEN-1:0]          alu_b;
	logic [`XLEN-1:0]          alu_res;
	logic [$clog2(`XLEN)-1:0]  shamt;
	logic [`XLEN-1:0]          link;
	logic [`XLEN-1:0]          br_target;
	logic [`XLEN-1:0]          jump_target;
	logic [`XLEN-1:0]          next_pc;
	logic                      taken;
	logic                      redirect_now;

	always_comb begin
		alu_a = d_op1;
		alu_b = d_op2;
		case (d_iclass)
			cls_lui: begin
				alu_a = d_pc;
				alu_b = d_imm;
			end
			// op-imm reads x0 as rs2 and op carries a zero imm
			cls_alu: alu_b = d_op2 | d_imm;
			cls_jump, cls_mem: alu_b = d_imm;
			default: ;
		endcase
	end

	assign shamt = alu_b[$clog2(`XLEN)-1:0];

	always_comb begin
		case (d_alu_op)
			add:     alu_res = alu_a + alu_b;
			sub:     alu_res = alu_a - alu_b;
			sll:     alu_res = alu_a << shamt;
			slt:     alu_res = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
			sltu:    alu_res = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
			xor_op:  alu_res = alu_a ^ alu_b;
			srl:     alu_res = alu_a >> shamt;
			sra:     alu_res = $unsigned($signed(alu_a) >>> shamt);
			or_op:   alu_res = alu_a | alu_b;
			and_op:  alu_res = alu_a & alu_b;
			default: alu_res = alu_b;
		endcase
	end

	always_comb begin
		case (d_funct3)
			3'b000:  taken = (d_op1 == d_op2);
			3'b001:  taken = (d_op1 != d_op2);
			3'b100:  taken = ($signed(d_op1) < $signed(d_op2));
			3'b101:  taken = ($signed(d_op1) >= $signed(d_op2));
			3'b110:  taken = (d_op1 < d_op2);
			3'b111:  taken = (d_op1 >= d_op2);
			default: taken = 1'b0;
		endcase
	end

	assign link      = d_pc + `XLEN'(4);
	assign br_target = d_pc + d_imm;
	// jal is tagged pass_b, jalr adds rs1 in the alu
	assign jump_target = (d_alu_op == pass_b) ? br_target : {alu_res[`XLEN-1:1], 1'b0};

	always_comb begin
		redirect_now = 1'b0;
		next_pc      = link;
		if (d_iclass == cls_jump) begin
			redirect_now = 1'b1;
			next_pc      = jump_target;
		end else if ((d_iclass == cls_branch) && taken) begin
			redirect_now = 1'b1;
			next_pc      = br_target;
		end
	end

	assign fwd_valid = d_valid && (d_rd != '0) &&
	                   (d_iclass != cls_branch) && (d_iclass != cls_mem);
	assign fwd_rd    = d_rd;
	assign fwd_value = (d_iclass == cls_jump) ? link : alu_res;

	always_ff @(posedge clk) begin
		if (rst) begin
			x_valid <= 1'b0;
		end else begin
			x_valid <= d_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid) begin
			x_iclass      <= d_iclass;
			x_rd          <= d_rd;
			x_alu_value   <= alu_res;
			x_link        <= link;
			x_redirect    <= redirect_now;
			x_redirect_pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_int_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_int_core (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  rv_pkg::instr_u              instr,
	input  logic [`XLEN-1:0]            pc,
	output logic                        res_valid,
	output logic                        res_wen,
	output logic [$clog2(`NREGS)-1:0]   res_rd,
	output logic [`XLEN-1:0]            res_value,
	output logic                        redirect,
	output logic [`XLEN-1:0]            redirect_pc
);
	import rv_pkg::*;

	logic [$clog2(`NREGS)-1:0] raddr1;
	logic [$clog2(`NREGS)-1:0] raddr2;
	logic [`XLEN-1:0]          rdata1;
	logic [`XLEN-1:0]          rdata2;
	logic                      wen;
	logic [$clog2(`NREGS)-1:0] waddr;
	logic [`XLEN-1:0]          wdata;

	logic                      fwd_valid;
	logic [$clog2(`NREGS)-1:0] fwd_rd;
	logic [`XLEN-1:0]          fwd_value;

	logic                      d_valid;
	logic [$clog2(`NREGS)-1:0] d_rd;
	logic [2:0]                d_funct3;
	logic [`XLEN-1:0]          d_op1;
	logic [`XLEN-1:0]          d_op2;
	logic [`XLEN-1:0]          d_imm;
	logic [`XLEN-1:0]          d_pc;
	alu_op_e                   d_alu_op;
	iclass_e                   d_iclass;

	logic                      x_valid;
	iclass_e                   x_iclass;
	logic [$clog2(`NREGS)-1:0] x_rd;
	logic [`XLEN-1:0]          x_alu_value;
	logic [`XLEN-1:0]          x_link;
	logic                      x_redirect;
	logic [`XLEN-1:0]          x_redirect_pc;

	rv_decode_stage u_decode (
		.clk, .rst, .in_valid, .instr, .pc,
		.fwd_valid, .fwd_rd, .fwd_value,
		.rdata1, .rdata2, .raddr1, .raddr2,
		.d_valid, .d_rd, .d_funct3, .d_op1, .d_op2,
		.d_imm, .d_pc, .d_alu_op, .d_iclass
	);

	rv_regfile u_regfile (
		.clk, .rst, .raddr1, .raddr2, .rdata1, .rdata2,
		.wen, .waddr, .wdata
	);

	rv_execute u_execute (
		.clk, .rst,
		.d_valid, .d_rd, .d_funct3, .d_op1, .d_op2,
		.d_imm, .d_pc, .d_alu_op, .d_iclass,
		.fwd_valid, .fwd_rd, .fwd_value,
		.x_valid, .x_iclass, .x_rd, .x_alu_value,
		.x_link, .x_redirect, .x_redirect_pc
	);

	rv_result u_result (
		.x_valid, .x_iclass, .x_rd, .x_alu_value,
		.x_link, .x_redirect, .x_redirect_pc,
		.wen, .waddr, .wdata,
		.res_valid, .res_wen, .res_rd, .res_value,
		.redirect, .redirect_pc
	);

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered over the word
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	typedef enum logic [3:0] {
		add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		cls_alu, cls_lui, cls_jump, cls_branch, cls_mem
	} iclass_e;

endpackage

`default_nettype wire

// ==== design/rv_pre_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_pre_decoder (
	input  rv_pkg::instr_u                  instr,
	output logic [$clog2(`NREGS)-1:0]       rd,
	output logic [$clog2(`NREGS)-1:0]       rs1,
	output logic [$clog2(`NREGS)-1:0]       rs2,
	output logic [2:0]                      funct3,
	output logic [6:0]                      funct7,
	output logic [`XLEN-1:0]                imm,
	output rv_pkg::alu_op_e                 alu_op,
	output rv_pkg::iclass_e                 iclass
);
	import rv_pkg::*;

	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] imm_sh;
	logic             is_shift;

	// funct7 bit 5 selects sub only for register operands
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
	                                     input logic is_reg);
		case (f3)
			3'b000:  return (alt && is_reg) ? sub : add;
			3'b001:  return sll;
			3'b010:  return slt;
			3'b011:  return sltu;
			3'b100:  return xor_op;
			3'b101:  return alt ? sra : srl;
			3'b110:  return or_op;
			default: return and_op;
		endcase
	endfunction

	assign imm_i = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_s = {{(`XLEN-12){instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
	                instr.s_fmt.imm_lo};
	assign imm_b = {{(`XLEN-12){instr.b_fmt.imm12}}, instr.b_fmt.imm11,
	                instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
	assign imm_u = {instr.u_fmt.imm, 12'b0};
	assign imm_j = {{(`XLEN-20){instr.j_fmt.imm20}}, instr.j_fmt.imm19_12,
	                instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
	// shamt sits in the rs2 slot
	assign imm_sh = {{(`XLEN-5){1'b0}}, instr.r_fmt.rs2};

	assign is_shift = (instr.i_fmt.funct3 == 3'b001) || (instr.i_fmt.funct3 == 3'b101);

	always_comb begin
		rd     = instr.r_fmt.rd;
		rs1    = instr.r_fmt.rs1;
		rs2    = instr.r_fmt.rs2;
		funct3 = instr.r_fmt.funct3;
		funct7 = instr.r_fmt.funct7;
		imm    = '0;
		iclass = cls_alu;
		alu_op = arith_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
		case (instr.r_fmt.opcode)
			opc_lui, opc_auipc: begin
				rd     = instr.u_fmt.rd;
				rs1    = '0;
				rs2    = '0;
				funct3 = '0;
				funct7 = '0;
				imm    = imm_u;
				iclass = cls_lui;
				alu_op = (instr.u_fmt.opcode == opc_lui) ? pass_b : add;
			end
			opc_jal: begin
				rd     = instr.j_fmt.rd;
				rs1    = '0;
				rs2    = '0;
				funct3 = '0;
				funct7 = '0;
				imm    = imm_j;
				iclass = cls_jump;
				alu_op = pass_b;
			end
			opc_jalr: begin
				rd     = instr.i_fmt.rd;
				rs1    = instr.i_fmt.rs1;
				rs2    = '0;
				funct7 = '0;
				imm    = imm_i;
				iclass = cls_jump;
				alu_op = add;
			end
			opc_branch: begin
				rd     = '0;
				rs1    = instr.b_fmt.rs1;
				rs2    = instr.b_fmt.rs2;
				funct3 = instr.b_fmt.funct3;
				funct7 = '0;
				imm    = imm_b;
				iclass = cls_branch;
				alu_op = sub;
			end
			opc_store: begin
				rd     = '0;
				rs1    = instr.s_fmt.rs1;
				rs2    = instr.s_fmt.rs2;
				funct7 = '0;
				imm    = imm_s;
				iclass = cls_mem;
				alu_op = add;
			end
			opc_load: begin
				rs1    = instr.i_fmt.rs1;
				rs2    = '0;
				funct7 = '0;
				imm    = imm_i;
				iclass = cls_mem;
				alu_op = add;
			end
			opc_op_imm: begin
				rs2    = '0;
				funct7 = is_shift ? instr.r_fmt.funct7 : 7'd0;
				imm    = is_shift ? imm_sh : imm_i;
				alu_op = arith_op(instr.i_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
			end
			// op and unknown opcodes keep the r-type defaults
			opc_op: ;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_regfile (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [$clog2(`NREGS)-1:0]   raddr1,
	input  logic [$clog2(`NREGS)-1:0]   raddr2,
	output logic [`XLEN-1:0]            rdata1,
	output logic [`XLEN-1:0]            rdata2,
	input  logic                        wen,
	input  logic [$clog2(`NREGS)-1:0]   waddr,
	input  logic [`XLEN-1:0]            wdata
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`NREGS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// write data bypasses to a read of the same address
	assign rdata1 = (raddr1 == '0)                ? '0    :
	                (wen && (waddr == raddr1))    ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0)                ? '0    :
	                (wen && (waddr == raddr2))    ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/rv_result.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_result (
	input  logic                        x_valid,
	input  rv_pkg::iclass_e             x_iclass,
	input  logic [$clog2(`NREGS)-1:0]   x_rd,
	input  logic [`XLEN-1:0]            x_alu_value,
	input  logic [`XLEN-1:0]            x_link,
	input  logic                        x_redirect,
	input  logic [`XLEN-1:0]            x_redirect_pc,
	output logic                        wen,
	output logic [$clog2(`NREGS)-1:0]   waddr,
	output logic [`XLEN-1:0]            wdata,
	output logic                        res_valid,
	output logic                        res_wen,
	output logic [$clog2(`NREGS)-1:0]   res_rd,
	output logic [`XLEN-1:0]            res_value,
	output logic                        redirect,
	output logic [`XLEN-1:0]            redirect_pc
);
	import rv_pkg::*;

	// branches and memory ops never write back
	assign wen   = x_valid && (x_rd != '0) &&
	               (x_iclass != cls_branch) && (x_iclass != cls_mem);
	assign waddr = x_rd;
	assign wdata = (x_iclass == cls_jump) ? x_link : x_alu_value;

	assign res_valid   = x_valid;
	assign res_wen     = wen;
	assign res_rd      = x_rd;
	assign res_value   = wdata;
	assign redirect    = x_valid && x_redirect;
	assign redirect_pc = x_redirect_pc;

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
+incdir+test
design/rv_pkg.sv
design/rv_pre_decoder.sv
design/rv_regfile.sv
design/rv_decode_stage.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_int_core.sv
test/tb_rv_int_core.sv

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
	logic                      wen;
	logic [$clog2(`NREGS)-1:0] rd;
	logic [`XLEN-1:0]          value;
	logic                      redirect;
	logic [`XLEN-1:0]          redirect_pc;
} expect_t;

// architectural state as seen in program order
logic [`XLEN-1:0] shadow [0:`NREGS-1];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
	return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
	return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
	return {imm[19:0], rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input logic [31:0] a,
                                        input logic [31:0] b);
	case (f3)
		3'b000:  return (alt && is_reg) ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return {31'b0, ($signed(a) < $signed(b))};
		3'b011:  return {31'b0, (a < b)};
		3'b100:  return a ^ b;
		// arithmetic form fills the vacated upper bits with the sign
		3'b101: begin
			if (alt) begin
				return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
			end
			return a >> b[4:0];
		end
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

function automatic expect_t ref_exec(input logic [31:0] iw, input logic [31:0] pc);
	expect_t     e;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [2:0]  f3;
	logic        taken;
	a     = shadow[iw[19:15]];
	b     = shadow[iw[24:20]];
	f3    = iw[14:12];
	imm_i = {{20{iw[31]}}, iw[31:20]};
	imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
	imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
	e     = '0;
	e.rd  = iw[11:7];
	e.wen = 1'b1;
	case (iw[6:0])
		opc_lui:   e.value = {iw[31:12], 12'b0};
		opc_auipc: e.value = pc + {iw[31:12], 12'b0};
		opc_jal: begin
			e.value       = pc + 32'd4;
			e.redirect    = 1'b1;
			e.redirect_pc = pc + imm_j;
		end
		opc_jalr: begin
			e.value       = pc + 32'd4;
			e.redirect    = 1'b1;
			e.redirect_pc = (a + imm_i) & ~32'd1;
		end
		opc_branch: begin
			case (f3)
				3'b000:  taken = (a == b);
				3'b001:  taken = (a != b);
				3'b100:  taken = ($signed(a) < $signed(b));
				3'b101:  taken = ($signed(a) >= $signed(b));
				3'b110:  taken = (a < b);
				3'b111:  taken = (a >= b);
				default: taken = 1'b0;
			endcase
			e.wen         = 1'b0;
			e.redirect    = taken;
			e.redirect_pc = pc + imm_b;
		end
		opc_op_imm: begin
			if (f3 == 3'b001 || f3 == 3'b101) begin
				e.value = alu_ref(f3, iw[30], 1'b0, a, {27'b0, iw[24:20]});
			end else begin
				e.value = alu_ref(f3, iw[30], 1'b0, a, imm_i);
			end
		end
		default: e.value = alu_ref(f3, iw[30], 1'b1, a, b);
	endcase
	if (e.rd == 5'd0) begin
		e.wen = 1'b0;
	end
	if (e.wen) begin
		shadow[e.rd] = e.value;
	end
	return e;
endfunction

`endif

// ==== test/tb_rv_int_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module tb_rv_int_core;
	import rv_pkg::*;

	localparam int drain_limit = 50;
	localparam logic [4:0] pair_a [0:4] = '{5'd11, 5'd10, 5'd11, 5'd11, 5'd13};
	localparam logic [4:0] pair_b [0:4] = '{5'd12, 5'd11, 5'd10, 5'd13, 5'd11};
	localparam logic [2:0] br_f3 [0:5]  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	logic                      clk;
	logic                      rst;
	logic                      in_valid;
	instr_u                    instr;
	logic [`XLEN-1:0]          pc;
	logic                      res_valid;
	logic                      res_wen;
	logic [$clog2(`NREGS)-1:0] res_rd;
	logic [`XLEN-1:0]          res_value;
	logic                      redirect;
	logic [`XLEN-1:0]          redirect_pc;

	integer           seed;
	int               value_errs;
	int               stray_errs;
	int               timeout_errs;
	logic [`XLEN-1:0] pc_next;

	`include "tb_ref_model.svh"

	expect_t want_q [$];

	rv_int_core dut (
		.clk, .rst, .in_valid, .instr, .pc,
		.res_valid, .res_wen, .res_rd, .res_value,
		.redirect, .redirect_pc
	);

	always #4 clk = ~clk;

	task automatic check_word(input string name, input logic [`XLEN-1:0] got,
	                          input logic [`XLEN-1:0] want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_reg(input string name, input logic [$clog2(`NREGS)-1:0] got,
	                         input logic [$clog2(`NREGS)-1:0] want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic compare_result(input expect_t want);
		check_bit("res_wen", res_wen, want.wen);
		if (want.wen) begin
			check_reg("res_rd", res_rd, want.rd);
			check_word("res_value", res_value, want.value);
		end
		check_bit("redirect", redirect, want.redirect);
		if (want.redirect) begin
			check_word("redirect_pc", redirect_pc, want.redirect_pc);
		end
	endtask

	// one expected entry per result strobe
	always @(negedge clk) begin
		if (!rst && res_valid) begin
			if (want_q.size() == 0) begin
				stray_errs++;
				$display("result strobe seen with no instruction outstanding");
			end else begin
				compare_result(want_q.pop_front());
			end
		end
	end

	function automatic logic [4:0] rand_reg(input logic [4:0] mask);
		logic [31:0] r;
		r = $random(seed);
		return r[4:0] & mask;
	endfunction

	// random op or op-imm over the registers in mask
	function automatic logic [31:0] rand_alu_instr(input logic [4:0] mask);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r  = $random(seed);
		f3 = r[2:0];
		f7 = {1'b0, r[3], 5'b0};
		if (r[4]) begin
			if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'h00;
			return enc_r(f7, rand_reg(mask), rand_reg(mask), f3, rand_reg(mask), opc_op);
		end
		if (f3 == 3'b001 || f3 == 3'b101) begin
			if (f3 == 3'b001) f7 = 7'h00;
			return enc_r(f7, r[9:5], rand_reg(mask), f3, rand_reg(mask), opc_op_imm);
		end
		return enc_i({20'b0, r[31:20]}, rand_reg(mask), f3, rand_reg(mask), opc_op_imm);
	endfunction

	task automatic issue_instr(input logic [31:0] word);
		instr    = word;
		pc       = pc_next;
		in_valid = 1'b1;
		want_q.push_back(ref_exec(word, pc_next));
		pc_next  = pc_next + 32'd4;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int cycles;
		cycles = 0;
		while (want_q.size() != 0 && cycles < drain_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (want_q.size() != 0) begin
			timeout_errs++;
			$display("timeout: %0d results of the %s group never came out", want_q.size(), what);
			want_q.delete();
		end
		#1;
	endtask

	task automatic jump_pc();
		logic [31:0] r;
		r       = $random(seed);
		pc_next = {r[31:2], 2'b00};
	endtask

	initial begin
		int i;
		int j;
		clk          = 1'b0;
		rst          = 1'b1;
		in_valid     = 1'b0;
		instr        = '0;
		pc           = '0;
		seed         = 72022;
		value_errs   = 0;
		stray_errs   = 0;
		timeout_errs = 0;
		pc_next      = 32'h0000_0100;
		for (i = 0; i < `NREGS; i++) begin
			shadow[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet after reset, then every register reads zero
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			check_bit("res_valid", res_valid, 1'b0);
			check_bit("res_wen", res_wen, 1'b0);
			check_bit("redirect", redirect, 1'b0);
		end
		@(posedge clk);
		#1;
		for (i = 0; i < `NREGS; i++) begin
			issue_instr(enc_r(7'h00, 5'd0, i[4:0], 3'b000, i[4:0], opc_op));
		end
		wait_drain("reset");

		// full random values via lui and addi
		for (i = 1; i < `NREGS; i++) begin
			issue_instr(enc_u($random(seed), i[4:0], opc_lui));
			issue_instr(enc_i($random(seed), i[4:0], 3'b000, i[4:0], opc_op_imm));
		end
		for (i = 0; i < 80; i++) begin
			issue_instr(rand_alu_instr(5'h1f));
		end
		// arithmetic shift of a negative value
		issue_instr(enc_u(32'h80000, 5'd5, opc_lui));
		issue_instr(enc_r(7'h20, 5'd4, 5'd5, 3'b101, 5'd6, opc_op_imm));
		issue_instr(enc_i(32'd7, 5'd0, 3'b000, 5'd7, opc_op_imm));
		issue_instr(enc_r(7'h20, 5'd7, 5'd5, 3'b101, 5'd8, opc_op));
		wait_drain("alu");

		// distance 1 and 2 on both sources
		issue_instr(enc_i(32'h123, 5'd0, 3'b000, 5'd1, opc_op_imm));
		issue_instr(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2, opc_op));
		issue_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opc_op));
		issue_instr(enc_r(7'h00, 5'd3, 5'd2, 3'b110, 5'd4, opc_op));
		issue_instr(enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5, opc_op));
		for (i = 0; i < 60; i++) begin
			issue_instr(rand_alu_instr(5'h03));
		end
		wait_drain("forwarding");

		for (i = 0; i < 12; i++) begin
			jump_pc();
			issue_instr(enc_u($random(seed), rand_reg(5'h1f), opc_lui));
			issue_instr(enc_u($random(seed), rand_reg(5'h1f), opc_auipc));
		end
		wait_drain("upper immediate");

		for (i = 0; i < 12; i++) begin
			jump_pc();
			issue_instr(enc_j($random(seed), rand_reg(5'h1f)));
			issue_instr(enc_i($random(seed), rand_reg(5'h1f), 3'b000, rand_reg(5'h1f), opc_jalr));
		end
		// jalr to an odd target with x0 as link
		issue_instr(enc_i(32'h200, 5'd0, 3'b000, 5'd1, opc_op_imm));
		issue_instr(enc_j(32'h40, 5'd0));
		issue_instr(enc_i(32'h7, 5'd1, 3'b000, 5'd0, opc_jalr));
		issue_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9, opc_op));
		wait_drain("jump");

		// -5, 3, 3 and 7 cover equal, less and greater both ways
		issue_instr(enc_i(-32'sd5, 5'd0, 3'b000, 5'd10, opc_op_imm));
		issue_instr(enc_i(32'd3, 5'd0, 3'b000, 5'd11, opc_op_imm));
		issue_instr(enc_i(32'd3, 5'd0, 3'b000, 5'd12, opc_op_imm));
		issue_instr(enc_i(32'd7, 5'd0, 3'b000, 5'd13, opc_op_imm));
		for (i = 0; i < 6; i++) begin
			for (j = 0; j < 5; j++) begin
				issue_instr(enc_b($random(seed), pair_b[j], pair_a[j], br_f3[i]));
			end
		end
		wait_drain("branch");

		$display("errors: value %0d, stray %0d, timeout %0d", value_errs, stray_errs,
		         timeout_errs);
		if (value_errs + stray_errs + timeout_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
